/* Makefile */
.PHONY: all run lint clean

all: run

obj_dir/VfroggerTb: build.f $(wildcard verilog/*.sv tb/*.sv)
	verilator --binary --assert -j 0 --top-module froggerTb -f build.f

run: obj_dir/VfroggerTb
	@out="$$(./obj_dir/VfroggerTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only -Wall --timing --top-module froggerTb -f build.f

clean:
	rm -rf obj_dir

/* build.f */
verilog/gamePkg.sv
verilog/fieldPkg.sv
verilog/laneIf.sv
verilog/moveDecoder.sv
verilog/gameCore.sv
verilog/trafficLanes.sv
verilog/scoreDisplay.sv
verilog/froggerTop.sv
tb/froggerTop_assertions.sv
tb/froggerTb.sv

/* tb/froggerTb.sv */
`timescale 1ns/1ps

module froggerTb;
    import fieldPkg::*;

    localparam int DEBOUNCE_LIMIT = 4;
    localparam int FIELD_W        = 16;
    localparam int BASE_X         = 8;
    localparam int CAR_PERIOD     = 1000000;
    localparam int HOLD_CYCLES    = 2 * DEBOUNCE_LIMIT;
    localparam int SETTLE_CYCLES  = DEBOUNCE_LIMIT + 4;
    localparam int SETTLE_TIMEOUT = 200;
    localparam int NUM_STEPS      = 16;
    localparam int NUM_RANDOM     = 40;

    localparam tileX_t BASE_COL = tileX_t'(BASE_X);
    // the lane 0 car sits at column 4*0 + 2 while the cars stand still
    localparam tileX_t CAR0_COL = tileX_t'(4 * 0 + 2);

    // switch bits are down, right, left, up from bit 3 to bit 0
    typedef struct packed {
        logic [3:0] switches;
        int         presses;
        int         hold;
        logic       expActive;
        tileX_t     expX;
        tileY_t     expY;
        logic [3:0] expDigit;
    } stepRow_t;

    localparam stepRow_t STEPS [NUM_STEPS] = '{
        '{4'b0001, 1, HOLD_CYCLES, 1'b0, BASE_COL, 3'd0, 4'd0},
        '{4'b0010, 1, HOLD_CYCLES, 1'b0, BASE_COL, 3'd0, 4'd0},
        '{4'b0100, 1, HOLD_CYCLES, 1'b0, BASE_COL, 3'd0, 4'd0},
        '{4'b1000, 1, HOLD_CYCLES, 1'b0, BASE_COL, 3'd0, 4'd0},
        '{4'b1111, 1, HOLD_CYCLES, 1'b1, BASE_COL, 3'd0, 4'd0},
        '{4'b0001, 1, HOLD_CYCLES, 1'b1, BASE_COL, 3'd1, 4'd0},
        '{4'b0100, 1, HOLD_CYCLES, 1'b1, BASE_COL + 5'd1, 3'd1, 4'd0},
        '{4'b0010, 1, HOLD_CYCLES, 1'b1, BASE_COL, 3'd1, 4'd0},
        '{4'b1000, 1, HOLD_CYCLES, 1'b1, BASE_COL, 3'd0, 4'd0},
        '{4'b0010, BASE_X + 1, HOLD_CYCLES, 1'b1, 5'd0, 3'd0, 4'd0},
        '{4'b0100, BASE_X, HOLD_CYCLES, 1'b1, BASE_COL, 3'd0, 4'd0},
        '{4'b0001, 5, HOLD_CYCLES, 1'b1, BASE_COL, 3'd0, 4'd1},
        '{4'b0010, BASE_X - 2, HOLD_CYCLES, 1'b1, CAR0_COL, 3'd0, 4'd1},
        '{4'b0001, 1, HOLD_CYCLES, 1'b0, BASE_COL, 3'd0, 4'd0},
        '{4'b1111, 1, HOLD_CYCLES, 1'b1, BASE_COL, 3'd0, 4'd0},
        '{4'b0100, FIELD_W - 2 - BASE_X, HOLD_CYCLES, 1'b1, tileX_t'(FIELD_W - 2), 3'd0, 4'd0}
    };

    logic        clk;
    logic        reset;
    logic [3:0]  switches;
    logic        active;
    tileX_t      frogX;
    tileY_t      frogY;
    logic [6:0]  segments;
    int          errorCount;
    int          testsRun;
    int          testsFailed;
    int          modelX;
    logic [31:0] lfsrState;

    froggerTop #(
        .DEBOUNCE_LIMIT(DEBOUNCE_LIMIT),
        .FIELD_W       (FIELD_W),
        .BASE_X        (BASE_X),
        .CAR_PERIOD    (CAR_PERIOD)
    ) uut (
        .i_Clk     (clk),
        .i_reset   (reset),
        .i_Switch1 (switches[0]),
        .i_Switch2 (switches[1]),
        .i_Switch3 (switches[2]),
        .i_Switch4 (switches[3]),
        .o_Active  (active),
        .o_FrogX   (frogX),
        .o_FrogY   (frogY),
        .o_Segments(segments)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // segment a is bit 6, segment g is bit 0
    function automatic logic [6:0] digitSegments(input logic [3:0] digit);
        case (digit)
            4'd0: return 7'b1111110;
            4'd1: return 7'b0110000;
            4'd2: return 7'b1101101;
            4'd3: return 7'b1111001;
            default: return 7'b0000000;
        endcase
    endfunction

    // taps 32, 22, 2 and 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // the outputs count as settled once they hold still for a whole debounce window
    task automatic settleOutputs();
        logic [15:0] previous;
        logic [15:0] current;
        int          stable;
        int          waited;
        stable = 0;
        waited = 0;
        @(negedge clk);
        previous = {active, frogX, frogY, segments};
        while (stable < SETTLE_CYCLES && waited < SETTLE_TIMEOUT)
        begin
            @(negedge clk);
            current = {active, frogX, frogY, segments};
            stable  = (current == previous) ? stable + 1 : 0;
            previous = current;
            waited++;
        end
        if (stable < SETTLE_CYCLES)
        begin
            $display("timeout: outputs were still changing %0d cycles after the release",
                     waited);
            errorCount++;
        end
    endtask

    task automatic pressSwitches(input logic [3:0] pattern, input int hold);
        @(posedge clk);
        switches <= pattern;
        repeat (hold) @(posedge clk);
        switches <= 4'b0000;
        settleOutputs();
    endtask

    task automatic checkOutputs(input string label, input int index, input logic expActive,
                                input tileX_t expX, input tileY_t expY,
                                input logic [3:0] expDigit);
        logic       ok;
        logic [6:0] expSegments;
        ok = 1'b1;
        expSegments = digitSegments(expDigit);
        assert (active == expActive)
        else
        begin
            $display("[ERROR] t=%0d ns %s %0d: o_Active %b, expected %b",
                     $time, label, index, active, expActive);
            ok = 1'b0;
        end
        assert (frogX == expX && frogY == expY)
        else
        begin
            $display("[ERROR] t=%0d ns %s %0d: frog at (%0d,%0d), expected (%0d,%0d)",
                     $time, label, index, frogX, frogY, expX, expY);
            ok = 1'b0;
        end
        assert (segments == expSegments)
        else
        begin
            $display("[ERROR] t=%0d ns %s %0d: o_Segments %b, expected %b for digit %0d",
                     $time, label, index, segments, expSegments, expDigit);
            ok = 1'b0;
        end
        testsRun++;
        if (!ok)
        begin
            testsFailed++;
            errorCount++;
        end
        $display("%s %0d: %s", label, index, ok ? "ok" : "mismatch");
    endtask

    initial
    begin
        reset       = 1'b1;
        switches    = 4'b0000;
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        modelX      = FIELD_W - 2;
        lfsrState   = 32'hd3ff;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkOutputs("reset", 0, 1'b0, BASE_COL, 3'd0, 4'd0);

        for (int i = 0; i < NUM_STEPS; i++)
        begin
            for (int p = 0; p < STEPS[i].presses; p++)
            begin
                pressSwitches(STEPS[i].switches, STEPS[i].hold);
            end
            checkOutputs("step", i, STEPS[i].expActive, STEPS[i].expX, STEPS[i].expY,
                         STEPS[i].expDigit);
        end

        // the random walk starts next to the right edge and takes one register bit per move
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            lfsrState = nextLfsr(lfsrState);
            if (lfsrState[0])
            begin
                pressSwitches(4'b0100, HOLD_CYCLES);
                modelX = (modelX < FIELD_W - 1) ? modelX + 1 : modelX;
            end
            else
            begin
                pressSwitches(4'b0010, HOLD_CYCLES);
                modelX = (modelX > 0) ? modelX - 1 : modelX;
            end
            checkOutputs("random", n, 1'b1, tileX_t'(modelX), 3'd0, 4'd0);
        end

        errorCount += uut.assertionsInst.assertFailures;
        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* tb/froggerTop_assertions.sv */
`timescale 1ns/1ps

module froggerTopAssertions #(
    parameter int FIELD_W = 16,
    parameter int BASE_X  = 8
) (
    input logic             i_Clk,
    input logic             i_reset,
    input logic             i_Active,
    input fieldPkg::tileX_t i_FrogX,
    input fieldPkg::tileY_t i_FrogY
);
    import fieldPkg::*;

    // read by the testbench at the end of the run
    int assertFailures = 0;

    activeLowAfterReset: assert property (@(posedge i_Clk) i_reset |=> !i_Active)
    else
    begin
        $error("game was active in the cycle after reset");
        assertFailures++;
    end

    frogInsideField: assert property (@(posedge i_Clk) disable iff (i_reset)
        (int'(i_FrogX) < FIELD_W) && (int'(i_FrogY) < NUM_ROWS))
    else
    begin
        $error("frog position left the field");
        assertFailures++;
    end

    // the run ends with the frog sent home in the same cycle
    frogHomeWhenIdle: assert property (@(posedge i_Clk) disable iff (i_reset)
        $fell(i_Active) |-> (int'(i_FrogX) == BASE_X) && (i_FrogY == START_ROW))
    else
    begin
        $error("game went idle with the frog away from the base tile");
        assertFailures++;
    end

endmodule

bind froggerTop froggerTopAssertions #(
    .FIELD_W(FIELD_W),
    .BASE_X (BASE_X)
) assertionsInst (
    .i_Clk   (i_Clk),
    .i_reset (i_reset),
    .i_Active(o_Active),
    .i_FrogX (o_FrogX),
    .i_FrogY (o_FrogY)
);

/* verilog/fieldPkg.sv */
package fieldPkg;

    // column index, wide enough for a field of up to 32 tiles
    typedef logic [4:0] tileX_t;

    // row index, row 0 is the start bank and the last row is the far bank
    typedef logic [2:0] tileY_t;

    localparam int NUM_LANES = 4;

    // start bank, four lanes and the far bank
    localparam int NUM_ROWS = NUM_LANES + 2;

    localparam tileY_t START_ROW = 3'd0;
    localparam tileY_t GOAL_ROW  = tileY_t'(NUM_ROWS - 1);

    // lane i starts its car at column 4*i + 2
    localparam tileX_t CAR_START [NUM_LANES] = '{
        5'd2,
        5'd6,
        5'd10,
        5'd14
    };

endpackage

/* verilog/froggerTop.sv */
`timescale 1ns/1ps

module froggerTop #(
    parameter int DEBOUNCE_LIMIT = 250000,
    parameter int FIELD_W        = 16,
    parameter int BASE_X         = 8,
    parameter int CAR_PERIOD     = 12500000
) (
    input  logic             i_Clk,
    input  logic             i_reset,
    input  logic             i_Switch1,
    input  logic             i_Switch2,
    input  logic             i_Switch3,
    input  logic             i_Switch4,
    output logic             o_Active,
    output fieldPkg::tileX_t o_FrogX,
    output fieldPkg::tileY_t o_FrogY,
    output logic [6:0]       o_Segments
);
    import gamePkg::*;

    logic   cmdValid;
    cmd_t   cmd;
    score_t score;

    laneIf lanesBus ();

    // switch 1 lands in bit 0 and decodes as up
    moveDecoder #(
        .DEBOUNCE_LIMIT(DEBOUNCE_LIMIT)
    ) moveDecoderInst (
        .i_Clk     (i_Clk),
        .i_reset   (i_reset),
        .i_Switch  ({i_Switch4, i_Switch3, i_Switch2, i_Switch1}),
        .o_CmdValid(cmdValid),
        .o_Cmd     (cmd)
    );

    gameCore #(
        .FIELD_W(FIELD_W),
        .BASE_X (BASE_X)
    ) gameCoreInst (
        .i_Clk     (i_Clk),
        .i_reset   (i_reset),
        .i_CmdValid(cmdValid),
        .i_Cmd     (cmd),
        .lanes     (lanesBus.core),
        .o_Active  (o_Active),
        .o_FrogX   (o_FrogX),
        .o_FrogY   (o_FrogY),
        .o_Score   (score)
    );

    trafficLanes #(
        .FIELD_W   (FIELD_W),
        .CAR_PERIOD(CAR_PERIOD)
    ) trafficLanesInst (
        .i_Clk  (i_Clk),
        .i_reset(i_reset),
        .lanes  (lanesBus.lanes)
    );

    scoreDisplay scoreDisplayInst (
        .i_Clk     (i_Clk),
        .i_reset   (i_reset),
        .i_Score   (score),
        .o_Segments(o_Segments)
    );

endmodule

/* verilog/gameCore.sv */
`timescale 1ns/1ps

module gameCore #(
    parameter int FIELD_W = 16,
    parameter int BASE_X  = 8
) (
    input  logic             i_Clk,
    input  logic             i_reset,
    input  logic             i_CmdValid,
    input  gamePkg::cmd_t    i_Cmd,
    laneIf.core              lanes,
    output logic             o_Active,
    output fieldPkg::tileX_t o_FrogX,
    output fieldPkg::tileY_t o_FrogY,
    output gamePkg::score_t  o_Score
);
    import gamePkg::*;
    import fieldPkg::*;

    localparam tileX_t RIGHT_EDGE = tileX_t'(FIELD_W - 1);
    localparam tileX_t BASE_COL   = tileX_t'(BASE_X);

    gameState_t state;
    tileX_t     frogX;
    tileY_t     frogY;
    score_t     score;
    logic       levelUp;
    logic       hit;

    // the frog is hit when it shares a tile with the car of the lane it stands in
    always_comb
    begin
        hit = 1'b0;
        for (int lane = 0; lane < NUM_LANES; lane++)
        begin
            if (frogY == tileY_t'(lane + 1) && frogX == lanes.carX[lane])
            begin
                hit = 1'b1;
            end
        end
    end

    always_ff @(posedge i_Clk)
    begin
        if (i_reset)
        begin
            state   <= IDLE;
            frogX   <= BASE_COL;
            frogY   <= START_ROW;
            score   <= '0;
            levelUp <= 1'b0;
        end
        else
        begin
            levelUp <= 1'b0;
            // a hit wins over any command arriving in the same cycle
            if (state == RUNNING && hit)
            begin
                state <= IDLE;
                frogX <= BASE_COL;
                frogY <= START_ROW;
                score <= '0;
            end
            else if (i_CmdValid)
            begin
                case (state)
                    IDLE:
                    begin
                        if (i_Cmd == CMD_START)
                        begin
                            state <= RUNNING;
                            frogX <= BASE_COL;
                            frogY <= START_ROW;
                        end
                    end
                    default:
                    begin
                        case (i_Cmd)
                            CMD_UP:
                            begin
                                if (frogY + 1'b1 == GOAL_ROW)
                                begin
                                    score   <= score + 1'b1;
                                    frogX   <= BASE_COL;
                                    frogY   <= START_ROW;
                                    levelUp <= 1'b1;
                                end
                                else
                                begin
                                    frogY <= frogY + 1'b1;
                                end
                            end
                            CMD_DOWN:
                            begin
                                if (frogY != START_ROW)
                                begin
                                    frogY <= frogY - 1'b1;
                                end
                            end
                            CMD_LEFT:
                            begin
                                if (frogX != '0)
                                begin
                                    frogX <= frogX - 1'b1;
                                end
                            end
                            CMD_RIGHT:
                            begin
                                if (frogX != RIGHT_EDGE)
                                begin
                                    frogX <= frogX + 1'b1;
                                end
                            end
                            default:
                            begin
                                frogX <= frogX;
                            end
                        endcase
                    end
                endcase
            end
        end
    end

    assign o_Active      = (state == RUNNING);
    assign o_FrogX       = frogX;
    assign o_FrogY       = frogY;
    assign o_Score       = score;
    assign lanes.levelUp = levelUp;
    assign lanes.level   = score;

endmodule

/* verilog/gamePkg.sv */
package gamePkg;

    // game flow states, IDLE waits for all four switches to be held
    typedef enum logic
    {
        IDLE    = 1'b0,
        RUNNING = 1'b1
    } gameState_t;

    // commands decoded from the switch presses
    typedef enum logic [2:0]
    {
        CMD_NONE  = 3'd0,
        CMD_UP    = 3'd1,
        CMD_LEFT  = 3'd2,
        CMD_RIGHT = 3'd3,
        CMD_DOWN  = 3'd4,
        CMD_START = 3'd5
    } cmd_t;

    // one hex digit of score, wraps from 15 back to 0
    typedef logic [3:0] score_t;

    // switch 1 is up, 2 is left, 3 is right and 4 is down
    localparam int NUM_SWITCHES = 4;

endpackage

/* verilog/laneIf.sv */
`timescale 1ns/1ps

interface laneIf;
    import fieldPkg::*;
    import gamePkg::*;

    // one car column per lane, lane 0 is row 1
    tileX_t [NUM_LANES-1:0] carX;

    // set bit means the car in that lane moves right
    logic [NUM_LANES-1:0] laneDir;

    // pulses for one cycle when the frog reaches the far bank
    logic levelUp;

    // follows the score and sets the car speed
    score_t level;

    modport core (input carX, output levelUp, output level);

    modport lanes (output carX, output laneDir, input levelUp, input level);

endinterface

/* verilog/moveDecoder.sv */
`timescale 1ns/1ps

module moveDecoder #(
    parameter int DEBOUNCE_LIMIT = 250000
) (
    input  logic                              i_Clk,
    input  logic                              i_reset,
    input  logic [gamePkg::NUM_SWITCHES-1:0]  i_Switch,
    output logic                              o_CmdValid,
    output gamePkg::cmd_t                     o_Cmd
);
    import gamePkg::*;

    localparam int CNT_W = $clog2(DEBOUNCE_LIMIT + 1);

    logic [CNT_W-1:0]        stableCount [NUM_SWITCHES];
    logic [NUM_SWITCHES-1:0] debounced;
    logic [NUM_SWITCHES-1:0] prevDebounced;
    logic [NUM_SWITCHES-1:0] newPress;
    cmd_t                    decodedCmd;

    // a switch has to disagree with its debounced level for DEBOUNCE_LIMIT cycles in a row
    always_ff @(posedge i_Clk)
    begin
        if (i_reset)
        begin
            debounced <= '0;
            for (int sw = 0; sw < NUM_SWITCHES; sw++)
            begin
                stableCount[sw] <= '0;
            end
        end
        else
        begin
            for (int sw = 0; sw < NUM_SWITCHES; sw++)
            begin
                if (i_Switch[sw] == debounced[sw])
                begin
                    stableCount[sw] <= '0;
                end
                else if (stableCount[sw] == CNT_W'(DEBOUNCE_LIMIT - 1))
                begin
                    debounced[sw]   <= i_Switch[sw];
                    stableCount[sw] <= '0;
                end
                else
                begin
                    stableCount[sw] <= stableCount[sw] + 1'b1;
                end
            end
        end
    end

    // only switches that just went down count, so releases stay silent
    assign newPress = debounced & ~prevDebounced;

    always_comb
    begin
        if (&debounced)
        begin
            decodedCmd = CMD_START;
        end
        else if (debounced[0])
        begin
            decodedCmd = CMD_UP;
        end
        else if (debounced[1])
        begin
            decodedCmd = CMD_LEFT;
        end
        else if (debounced[2])
        begin
            decodedCmd = CMD_RIGHT;
        end
        else if (debounced[3])
        begin
            decodedCmd = CMD_DOWN;
        end
        else
        begin
            decodedCmd = CMD_NONE;
        end
    end

    always_ff @(posedge i_Clk)
    begin
        if (i_reset)
        begin
            prevDebounced <= '0;
            o_CmdValid    <= 1'b0;
            o_Cmd         <= CMD_NONE;
        end
        else
        begin
            prevDebounced <= debounced;
            o_CmdValid    <= |newPress;
            o_Cmd         <= (|newPress) ? decodedCmd : CMD_NONE;
        end
    end

endmodule

/* verilog/scoreDisplay.sv */
`timescale 1ns/1ps

module scoreDisplay (
    input  logic            i_Clk,
    input  logic            i_reset,
    input  gamePkg::score_t i_Score,
    output logic [6:0]      o_Segments
);
    import gamePkg::*;

    // bit 6 is segment a down to bit 0 for segment g, a lit segment is 1
    localparam logic [6:0] DIGIT_ZERO = 7'b1111110;

    logic [6:0] pattern;

    always_comb
    begin
        case (i_Score)
            4'h0: pattern = DIGIT_ZERO;
            4'h1: pattern = 7'b0110000;
            4'h2: pattern = 7'b1101101;
            4'h3: pattern = 7'b1111001;
            4'h4: pattern = 7'b0110011;
            4'h5: pattern = 7'b1011011;
            4'h6: pattern = 7'b1011111;
            4'h7: pattern = 7'b1110000;
            4'h8: pattern = 7'b1111111;
            4'h9: pattern = 7'b1111011;
            4'hA: pattern = 7'b1110111;
            4'hB: pattern = 7'b0011111;
            4'hC: pattern = 7'b1001110;
            4'hD: pattern = 7'b0111101;
            4'hE: pattern = 7'b1001111;
            default: pattern = 7'b1000111;
        endcase
    end

    always_ff @(posedge i_Clk)
    begin
        if (i_reset)
        begin
            o_Segments <= DIGIT_ZERO;
        end
        else
        begin
            o_Segments <= pattern;
        end
    end

endmodule

/* verilog/trafficLanes.sv */
`timescale 1ns/1ps

module trafficLanes #(
    parameter int FIELD_W    = 16,
    parameter int CAR_PERIOD = 12500000
) (
    input  logic i_Clk,
    input  logic i_reset,
    laneIf.lanes lanes
);
    import fieldPkg::*;

    localparam int         CNT_W      = $clog2(CAR_PERIOD + 1);
    localparam tileX_t     RIGHT_EDGE = tileX_t'(FIELD_W - 1);
    localparam logic [3:0] LFSR_SEED  = 4'b1001;

    logic [CNT_W-1:0]       stepCount;
    logic [CNT_W-1:0]       stepLimit;
    logic [1:0]             speedShift;
    logic                   stepTick;
    logic [3:0]             lfsr;
    logic [NUM_LANES-1:0]   dirBits;
    tileX_t [NUM_LANES-1:0] carPos;

    // each point halves the step period, three halvings at most
    assign speedShift = (lanes.level > 4'd3) ? 2'd3 : lanes.level[1:0];
    assign stepLimit  = CNT_W'(CAR_PERIOD) >> speedShift;
    assign stepTick   = (stepCount + 1'b1) >= stepLimit;

    always_ff @(posedge i_Clk)
    begin
        if (i_reset || stepTick)
        begin
            stepCount <= '0;
        end
        else
        begin
            stepCount <= stepCount + 1'b1;
        end
    end

    // x^4 + x^3 + 1, runs through all 15 nonzero states
    always_ff @(posedge i_Clk)
    begin
        if (i_reset)
        begin
            lfsr    <= LFSR_SEED;
            dirBits <= LFSR_SEED;
        end
        else
        begin
            lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
            if (lanes.levelUp || dirBits == '0)
            begin
                dirBits <= lfsr;
            end
        end
    end

    always_ff @(posedge i_Clk)
    begin
        if (i_reset)
        begin
            for (int lane = 0; lane < NUM_LANES; lane++)
            begin
                carPos[lane] <= CAR_START[lane];
            end
        end
        else if (stepTick)
        begin
            for (int lane = 0; lane < NUM_LANES; lane++)
            begin
                if (dirBits[lane])
                begin
                    carPos[lane] <= (carPos[lane] == RIGHT_EDGE) ? '0 : carPos[lane] + 1'b1;
                end
                else
                begin
                    carPos[lane] <= (carPos[lane] == '0) ? RIGHT_EDGE : carPos[lane] - 1'b1;
                end
            end
        end
    end

    assign lanes.carX    = carPos;
    assign lanes.laneDir = dirBits;

endmodule
